// ==== rtl/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  localparam int XLEN   = 32;
  localparam int OP_W   = 6;
  localparam int ADDR_W = 5;

  // ------------------------------------------------------------------
  // Operation codes
  // ------------------------------------------------------------------
  localparam logic [OP_W-1:0] OP_ADD       = 6'd0;
  localparam logic [OP_W-1:0] OP_SUB       = 6'd1;
  localparam logic [OP_W-1:0] OP_AND       = 6'd2;
  localparam logic [OP_W-1:0] OP_OR        = 6'd3;
  localparam logic [OP_W-1:0] OP_XOR       = 6'd4;
  localparam logic [OP_W-1:0] OP_ANDN      = 6'd5;
  localparam logic [OP_W-1:0] OP_ORN       = 6'd6;
  localparam logic [OP_W-1:0] OP_XNOR      = 6'd7;
  localparam logic [OP_W-1:0] OP_SLL       = 6'd8;
  localparam logic [OP_W-1:0] OP_SRL       = 6'd9;
  localparam logic [OP_W-1:0] OP_SRA       = 6'd10;
  localparam logic [OP_W-1:0] OP_SLTS      = 6'd11;
  localparam logic [OP_W-1:0] OP_SLTU      = 6'd12;
  // Branch compares
  localparam logic [OP_W-1:0] OP_EQ        = 6'd13;
  localparam logic [OP_W-1:0] OP_NE        = 6'd14;
  localparam logic [OP_W-1:0] OP_LTS       = 6'd15;
  localparam logic [OP_W-1:0] OP_LTU       = 6'd16;
  localparam logic [OP_W-1:0] OP_GES       = 6'd17;
  localparam logic [OP_W-1:0] OP_GEU       = 6'd18;
  // Bit manipulation
  localparam logic [OP_W-1:0] OP_MIN       = 6'd19;
  localparam logic [OP_W-1:0] OP_MAX       = 6'd20;
  localparam logic [OP_W-1:0] OP_MINU      = 6'd21;
  localparam logic [OP_W-1:0] OP_MAXU      = 6'd22;
  localparam logic [OP_W-1:0] OP_CLZ       = 6'd23;
  localparam logic [OP_W-1:0] OP_CTZ       = 6'd24;
  localparam logic [OP_W-1:0] OP_CPOP      = 6'd25;
  localparam logic [OP_W-1:0] OP_SEXTB     = 6'd26;
  localparam logic [OP_W-1:0] OP_SEXTH     = 6'd27;
  localparam logic [OP_W-1:0] OP_ZEXTH     = 6'd28;
  localparam logic [OP_W-1:0] OP_ROL       = 6'd29;
  localparam logic [OP_W-1:0] OP_ROR       = 6'd30;
  localparam logic [OP_W-1:0] OP_ORCB      = 6'd31;
  localparam logic [OP_W-1:0] OP_REV8      = 6'd32;
  localparam logic [OP_W-1:0] OP_BCLR      = 6'd33;
  localparam logic [OP_W-1:0] OP_BSET      = 6'd34;
  localparam logic [OP_W-1:0] OP_BINV      = 6'd35;
  localparam logic [OP_W-1:0] OP_BEXT      = 6'd36;
  localparam logic [OP_W-1:0] OP_SH1ADD    = 6'd37;
  localparam logic [OP_W-1:0] OP_SH2ADD    = 6'd38;
  localparam logic [OP_W-1:0] OP_SH3ADD    = 6'd39;
  // Conditional zero
  localparam logic [OP_W-1:0] OP_CZERO_EQZ = 6'd40;
  localparam logic [OP_W-1:0] OP_CZERO_NEZ = 6'd41;

  // ------------------------------------------------------------------
  // Register map, word addresses from bus address bits 4:2
  // ------------------------------------------------------------------
  localparam logic [2:0] REG_OPA    = 3'd0;
  localparam logic [2:0] REG_OPB    = 3'd1;
  localparam logic [2:0] REG_OP     = 3'd2;
  localparam logic [2:0] REG_RESULT = 3'd3;
  localparam logic [2:0] REG_BRANCH = 3'd4;

endpackage

`default_nettype wire

// ==== rtl/popcount.sv ====
`timescale 1ns/10ps
`default_nettype none

module popcount
  import alu_pkg::*;
#(
  parameter int WIDTH = XLEN
) (
  input  logic [WIDTH-1:0]       data_i,
  output logic [$clog2(WIDTH):0] popcount_o
);

  generate
    if (WIDTH == 1) begin : g_leaf
      assign popcount_o = data_i;
    end else begin : g_node
      // Split into two halves and add the partial counts
      localparam int LO_W = WIDTH / 2;
      localparam int HI_W = WIDTH - LO_W;

      logic [$clog2(LO_W):0] lo_cnt;
      logic [$clog2(HI_W):0] hi_cnt;

      popcount #(.WIDTH(LO_W)) lo (
        .data_i    (data_i[LO_W-1:0]),
        .popcount_o(lo_cnt)
      );

      popcount #(.WIDTH(HI_W)) hi (
        .data_i    (data_i[WIDTH-1:LO_W]),
        .popcount_o(hi_cnt)
      );

      assign popcount_o = ($clog2(WIDTH)+1)'(lo_cnt) + ($clog2(WIDTH)+1)'(hi_cnt);
    end
  endgenerate

endmodule

`default_nettype wire

// ==== rtl/lzc.sv ====
`timescale 1ns/10ps
`default_nettype none

module lzc
  import alu_pkg::*;
#(
  parameter int WIDTH = XLEN
) (
  input  logic [WIDTH-1:0]         in_i,
  output logic [$clog2(WIDTH)-1:0] cnt_o,
  output logic                     empty_o
);

  localparam int LEVELS = $clog2(WIDTH);
  localparam int LEAVES = 2 ** LEVELS;

  // Tree position 0 holds the MSB, padding bits stay zero
  logic [LEAVES-1:0] in_rev;
  logic [LEAVES-2:0] sel_nodes;
  logic [LEVELS-1:0] idx_nodes [LEAVES-1];

  always_comb begin
    in_rev = '0;
    for (int i = 0; i < WIDTH; i++) begin
      in_rev[i] = in_i[WIDTH-1-i];
    end
  end

  // ------------------------------------------------------------------
  // Priority tree, node ID has children 2*ID+1 and 2*ID+2
  // ------------------------------------------------------------------
  for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
    for (genvar n = 0; n < 2 ** lvl; n++) begin : g_node
      localparam int ID = 2 ** lvl - 1 + n;
      if (lvl == LEVELS - 1) begin : g_leaf
        assign sel_nodes[ID] = in_rev[2*n] | in_rev[2*n+1];
        assign idx_nodes[ID] = in_rev[2*n] ? LEVELS'(2*n) : LEVELS'(2*n+1);
      end else begin : g_inner
        // Left child is nearer the MSB and wins
        assign sel_nodes[ID] = sel_nodes[2*ID+1] | sel_nodes[2*ID+2];
        assign idx_nodes[ID] = sel_nodes[2*ID+1] ? idx_nodes[2*ID+1] : idx_nodes[2*ID+2];
      end
    end
  end

  assign cnt_o   = idx_nodes[0];
  assign empty_o = ~sel_nodes[0];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu
  import alu_pkg::*;
(
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  input  logic [OP_W-1:0] operation_i,
  output logic [XLEN-1:0] result_o,
  output logic            branch_res_o
);

  logic [XLEN-1:0]          operand_a_rev;
  logic [$clog2(XLEN)-1:0]  shamt;

  assign shamt = operand_b_i[$clog2(XLEN)-1:0];

  for (genvar k = 0; k < XLEN; k++) begin : g_rev_a
    assign operand_a_rev[k] = operand_a_i[XLEN-1-k];
  end

  // ------------------------------------------------------------------
  // Adder
  // ------------------------------------------------------------------
  logic            negate_b;
  logic [XLEN-1:0] adder_a;
  logic [XLEN:0]   operand_b_neg;
  logic [XLEN:0]   adder_sum;
  logic [XLEN-1:0] adder_result;
  logic            adder_zero;

  always_comb begin
    case (operation_i)
      OP_SUB, OP_EQ, OP_NE, OP_ANDN, OP_ORN, OP_XNOR: negate_b = 1'b1;
      default: negate_b = 1'b0;
    endcase
  end

  always_comb begin
    case (operation_i)
      OP_SH1ADD: adder_a = operand_a_i << 1;
      OP_SH2ADD: adder_a = operand_a_i << 2;
      OP_SH3ADD: adder_a = operand_a_i << 3;
      default:   adder_a = operand_a_i;
    endcase
  end

  // Extra low bit carries the +1 of the two's complement
  assign operand_b_neg = {operand_b_i, 1'b0} ^ {(XLEN+1){negate_b}};
  assign adder_sum     = {adder_a, 1'b1} + operand_b_neg;
  assign adder_result  = adder_sum[XLEN:1];
  assign adder_zero    = ~|adder_result;

  // ------------------------------------------------------------------
  // Compare
  // ------------------------------------------------------------------
  logic signed_cmp;
  logic less;

  always_comb begin
    case (operation_i)
      OP_SLTS, OP_LTS, OP_GES, OP_MIN, OP_MAX: signed_cmp = 1'b1;
      default: signed_cmp = 1'b0;
    endcase
  end

  assign less = $signed({signed_cmp & operand_a_i[XLEN-1], operand_a_i}) <
                $signed({signed_cmp & operand_b_i[XLEN-1], operand_b_i});

  always_comb begin
    case (operation_i)
      OP_EQ:          branch_res_o = adder_zero;
      OP_NE:          branch_res_o = ~adder_zero;
      OP_LTS, OP_LTU: branch_res_o = less;
      OP_GES, OP_GEU: branch_res_o = ~less;
      default:        branch_res_o = 1'b1;
    endcase
  end

  // ------------------------------------------------------------------
  // Shifter, left shifts reuse the right shifter on reversed bits
  // ------------------------------------------------------------------
  logic            shift_left;
  logic            shift_arith;
  logic [XLEN-1:0] shift_in;
  logic [XLEN:0]   shift_ext;
  logic [XLEN-1:0] shift_right;
  logic [XLEN-1:0] shift_rev;
  logic [XLEN-1:0] shift_result;

  assign shift_left  = (operation_i == OP_SLL);
  assign shift_arith = (operation_i == OP_SRA);
  assign shift_in    = shift_left ? operand_a_rev : operand_a_i;
  assign shift_ext   = {shift_arith & shift_in[XLEN-1], shift_in};
  assign shift_right = XLEN'($signed(shift_ext) >>> shamt);

  for (genvar k = 0; k < XLEN; k++) begin : g_rev_shift
    assign shift_rev[k] = shift_right[XLEN-1-k];
  end

  assign shift_result = shift_left ? shift_rev : shift_right;

  // ------------------------------------------------------------------
  // Bit manipulation
  // ------------------------------------------------------------------
  logic [XLEN-1:0]         bitmanip_op;
  logic [$clog2(XLEN):0]   cpop_cnt;
  logic [$clog2(XLEN)-1:0] lz_cnt;
  logic                    lz_empty;
  logic [XLEN-1:0]         zero_count;
  logic [XLEN-1:0]         bit_mask;
  logic [XLEN-1:0]         rol_result;
  logic [XLEN-1:0]         ror_result;
  logic [XLEN-1:0]         orcb_result;
  logic [XLEN-1:0]         rev8_result;

  // Trailing zeros are leading zeros of the reversed word
  assign bitmanip_op = (operation_i == OP_CTZ) ? operand_a_rev : operand_a_i;

  popcount #(.WIDTH(XLEN)) cpop0 (
    .data_i    (bitmanip_op),
    .popcount_o(cpop_cnt)
  );

  lzc #(.WIDTH(XLEN)) lzc0 (
    .in_i   (bitmanip_op),
    .cnt_o  (lz_cnt),
    .empty_o(lz_empty)
  );

  // Zero word gives XLEN-1 from lzc, plus one
  assign zero_count = XLEN'(lz_cnt) + XLEN'(lz_empty);
  assign bit_mask   = XLEN'(1) << shamt;
  assign rol_result = (operand_a_i << shamt) | (operand_a_i >> (XLEN - shamt));
  assign ror_result = (operand_a_i >> shamt) | (operand_a_i << (XLEN - shamt));

  for (genvar b = 0; b < XLEN / 8; b++) begin : g_bytes
    assign orcb_result[8*b +: 8] = {8{|operand_a_i[8*b +: 8]}};
    assign rev8_result[8*b +: 8] = operand_a_i[XLEN-8-8*b +: 8];
  end

  // ------------------------------------------------------------------
  // Result mux
  // ------------------------------------------------------------------
  always_comb begin
    case (operation_i)
      OP_ADD, OP_SUB, OP_SH1ADD, OP_SH2ADD, OP_SH3ADD: result_o = adder_result;
      OP_AND, OP_ANDN: result_o = operand_a_i & operand_b_neg[XLEN:1];
      OP_OR, OP_ORN:   result_o = operand_a_i | operand_b_neg[XLEN:1];
      OP_XOR, OP_XNOR: result_o = operand_a_i ^ operand_b_neg[XLEN:1];
      OP_SLL, OP_SRL, OP_SRA: result_o = shift_result;
      OP_SLTS, OP_SLTU: result_o = XLEN'(less);
      OP_MIN, OP_MINU:  result_o = less ? operand_a_i : operand_b_i;
      OP_MAX, OP_MAXU:  result_o = less ? operand_b_i : operand_a_i;
      OP_CLZ, OP_CTZ:   result_o = zero_count;
      OP_CPOP:          result_o = XLEN'(cpop_cnt);
      OP_SEXTB: result_o = {{(XLEN-8){operand_a_i[7]}}, operand_a_i[7:0]};
      OP_SEXTH: result_o = {{(XLEN-16){operand_a_i[15]}}, operand_a_i[15:0]};
      OP_ZEXTH: result_o = {{(XLEN-16){1'b0}}, operand_a_i[15:0]};
      OP_ROL:   result_o = rol_result;
      OP_ROR:   result_o = ror_result;
      OP_ORCB:  result_o = orcb_result;
      OP_REV8:  result_o = rev8_result;
      OP_BCLR:  result_o = operand_a_i & ~bit_mask;
      OP_BSET:  result_o = operand_a_i | bit_mask;
      OP_BINV:  result_o = operand_a_i ^ bit_mask;
      OP_BEXT:  result_o = XLEN'(|(operand_a_i & bit_mask));
      OP_CZERO_EQZ: result_o = (|operand_b_i) ? operand_a_i : '0;
      OP_CZERO_NEZ: result_o = (|operand_b_i) ? '0 : operand_a_i;
      // Branch compares and undefined codes
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/alu_wb_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_wb_regs
  import alu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  // Wishbone classic slave
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic [XLEN-1:0]   wb_dat_i,
  input  logic [XLEN/8-1:0] wb_sel_i,
  output logic [XLEN-1:0]   wb_dat_o,
  output logic              wb_ack_o,
  // ALU side
  output logic [XLEN-1:0]   operand_a_o,
  output logic [XLEN-1:0]   operand_b_o,
  output logic [OP_W-1:0]   operation_o,
  input  logic [XLEN-1:0]   result_i,
  input  logic              branch_res_i
);

  logic            ack_q;
  logic            req;
  logic            wr_en;
  logic            rd_en;
  logic [2:0]      word_adr;
  logic [XLEN-1:0] rd_data;

  assign word_adr = wb_adr_i[4:2];

  // Ack blocks the next sample, so a held strobe is not acked twice
  assign req      = wb_cyc_i & wb_stb_i & ~ack_q;
  assign wr_en    = req & wb_we_i;
  assign rd_en    = req & ~wb_we_i;
  assign wb_ack_o = ack_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // ------------------------------------------------------------------
  // Writable registers with byte lanes
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      operand_a_o <= '0;
      operand_b_o <= '0;
      operation_o <= '0;
    end else if (wr_en) begin
      for (int i = 0; i < XLEN / 8; i++) begin
        if (wb_sel_i[i]) begin
          if (word_adr == REG_OPA) begin
            operand_a_o[8*i +: 8] <= wb_dat_i[8*i +: 8];
          end
          if (word_adr == REG_OPB) begin
            operand_b_o[8*i +: 8] <= wb_dat_i[8*i +: 8];
          end
        end
      end
      // Operation code sits in lane 0 only
      if (word_adr == REG_OP && wb_sel_i[0]) begin
        operation_o <= wb_dat_i[OP_W-1:0];
      end
    end
  end

  // ------------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------------
  always_comb begin
    case (word_adr)
      REG_OPA:    rd_data = operand_a_o;
      REG_OPB:    rd_data = operand_b_o;
      REG_OP:     rd_data = XLEN'(operation_o);
      REG_RESULT: rd_data = result_i;
      REG_BRANCH: rd_data = XLEN'(branch_res_i);
      default:    rd_data = '0;
    endcase
  end

  // Captured on the ack edge
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      wb_dat_o <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/alu_wb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_wb_top
  import alu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic [XLEN-1:0]   wb_dat_i,
  input  logic [XLEN/8-1:0] wb_sel_i,
  output logic [XLEN-1:0]   wb_dat_o,
  output logic              wb_ack_o
);

  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;
  logic [OP_W-1:0] operation;
  logic [XLEN-1:0] result;
  logic            branch_res;

  // Bus register block
  alu_wb_regs regs0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .operand_a_o (operand_a),
    .operand_b_o (operand_b),
    .operation_o (operation),
    .result_i    (result),
    .branch_res_i(branch_res)
  );

  // Combinational datapath
  alu alu0 (
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .operation_i (operation),
    .result_o    (result),
    .branch_res_o(branch_res)
  );

endmodule

`default_nettype wire

// ==== verification/tb_alu_model.svh ====
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// One xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] state);
  logic [31:0] x;
  x = state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Register contents after a byte-lane write
function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                            input logic [31:0] new_val,
                                            input logic [3:0]  sel);
  logic [31:0] r;
  r = old_val;
  for (int i = 0; i < 4; i++) begin
    if (sel[i]) begin
      r[8*i +: 8] = new_val[8*i +: 8];
    end
  end
  return r;
endfunction

// ----------------------------------------------------------------------
// Reference model of the ALU result word
// ----------------------------------------------------------------------
function automatic logic [31:0] model_result(input logic [OP_W-1:0] op,
                                             input logic [31:0] a,
                                             input logic [31:0] b);
  logic [4:0]  sh;
  logic [63:0] dbl;
  logic [31:0] r;
  int          n;
  sh = b[4:0];
  r  = '0;
  n  = 0;
  case (op)
    OP_ADD:  r = a + b;
    OP_SUB:  r = a - b;
    OP_AND:  r = a & b;
    OP_OR:   r = a | b;
    OP_XOR:  r = a ^ b;
    OP_ANDN: r = a & ~b;
    OP_ORN:  r = a | ~b;
    OP_XNOR: r = ~(a ^ b);
    OP_SLL:  r = a << sh;
    OP_SRL:  r = a >> sh;
    OP_SRA:  r = $signed(a) >>> sh;
    OP_SLTS: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    OP_SLTU: r = (a < b) ? 32'd1 : 32'd0;
    OP_MIN:  r = ($signed(a) < $signed(b)) ? a : b;
    OP_MAX:  r = ($signed(a) < $signed(b)) ? b : a;
    OP_MINU: r = (a < b) ? a : b;
    OP_MAXU: r = (a < b) ? b : a;
    OP_CLZ: begin
      // Highest set bit wins
      n = 32;
      for (int i = 0; i < 32; i++) begin
        if (a[i]) n = 31 - i;
      end
      r = n;
    end
    OP_CTZ: begin
      n = 32;
      for (int i = 31; i >= 0; i--) begin
        if (a[i]) n = i;
      end
      r = n;
    end
    OP_CPOP: begin
      for (int i = 0; i < 32; i++) begin
        if (a[i]) n++;
      end
      r = n;
    end
    OP_SEXTB: r = {{24{a[7]}}, a[7:0]};
    OP_SEXTH: r = {{16{a[15]}}, a[15:0]};
    OP_ZEXTH: r = {16'h0000, a[15:0]};
    OP_ROL: begin
      dbl = {a, a} << sh;
      r   = dbl[63:32];
    end
    OP_ROR: begin
      dbl = {a, a} >> sh;
      r   = dbl[31:0];
    end
    OP_ORCB: begin
      for (int k = 0; k < 4; k++) begin
        r[8*k +: 8] = (a[8*k +: 8] != 8'h00) ? 8'hff : 8'h00;
      end
    end
    OP_REV8: r = {a[7:0], a[15:8], a[23:16], a[31:24]};
    OP_BCLR: begin
      r     = a;
      r[sh] = 1'b0;
    end
    OP_BSET: begin
      r     = a;
      r[sh] = 1'b1;
    end
    OP_BINV: begin
      r     = a;
      r[sh] = ~a[sh];
    end
    OP_BEXT:      r = {31'b0, a[sh]};
    OP_SH1ADD:    r = {a[30:0], 1'b0} + b;
    OP_SH2ADD:    r = {a[29:0], 2'b00} + b;
    OP_SH3ADD:    r = {a[28:0], 3'b000} + b;
    OP_CZERO_EQZ: r = (b == 32'd0) ? 32'd0 : a;
    OP_CZERO_NEZ: r = (b != 32'd0) ? 32'd0 : a;
    default:      r = '0;
  endcase
  return r;
endfunction

// Branch flag, high for anything that is not a compare
function automatic logic model_branch(input logic [OP_W-1:0] op,
                                      input logic [31:0] a,
                                      input logic [31:0] b);
  case (op)
    OP_EQ:   return a == b;
    OP_NE:   return a != b;
    OP_LTS:  return $signed(a) < $signed(b);
    OP_LTU:  return a < b;
    OP_GES:  return $signed(a) >= $signed(b);
    OP_GEU:  return a >= b;
    default: return 1'b1;
  endcase
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
  if (got !== exp) begin
    $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
    fail_cnt++;
  end else begin
    pass_cnt++;
  end
endtask

`endif

// ==== verification/tb_alu_wb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_alu_wb_top
  import alu_pkg::*;
();

  logic              clk_i;
  logic              rst_i;
  logic              wb_cyc_i;
  logic              wb_stb_i;
  logic              wb_we_i;
  logic [ADDR_W-1:0] wb_adr_i;
  logic [XLEN-1:0]   wb_dat_i;
  logic [3:0]        wb_sel_i;
  logic [XLEN-1:0]   wb_dat_o;
  logic              wb_ack_o;

  int          pass_cnt;
  int          fail_cnt;
  int          test_fail;
  logic [31:0] rng;

  alu_wb_top dut0 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .wb_cyc_i(wb_cyc_i),
    .wb_stb_i(wb_stb_i),
    .wb_we_i (wb_we_i),
    .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i),
    .wb_sel_i(wb_sel_i),
    .wb_dat_o(wb_dat_o),
    .wb_ack_o(wb_ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // Bus master tasks sampling outputs on the falling edge
  // ----------------------------------------------------------------------
  task automatic wait_ack(input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!wb_ack_o && n < 20) begin
      @(negedge clk_i);
      n++;
    end
    if (!wb_ack_o) begin
      $display("Timeout: no ack within 20 cycles on a %s", what);
      fail_cnt++;
    end
  endtask

  task automatic wb_write(input logic [2:0] word, input logic [31:0] data,
                          input logic [3:0] sel);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b1;
    wb_adr_i <= {word, 2'b00};
    wb_dat_i <= data;
    wb_sel_i <= sel;
    wait_ack("write");
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  task automatic wb_read(input logic [2:0] word, output logic [31:0] data);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b0;
    wb_adr_i <= {word, 2'b00};
    wb_sel_i <= 4'hf;
    wait_ack("read");
    data = wb_dat_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  // Load both operands and the code, then fetch result and flag
  task automatic run_op(input logic [OP_W-1:0] op, input logic [31:0] a,
                        input logic [31:0] b, output logic [31:0] res,
                        output logic [31:0] br);
    wb_write(REG_OPA, a, 4'hf);
    wb_write(REG_OPB, b, 4'hf);
    wb_write(REG_OP, 32'(op), 4'hf);
    wb_read(REG_RESULT, res);
    wb_read(REG_BRANCH, br);
  endtask

  task automatic next_rand(output logic [31:0] v);
    rng = xorshift32(rng);
    v   = rng;
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished with %0d errors", name, fail_cnt - test_fail);
    test_fail = fail_cnt;
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     res;
    logic [31:0]     br;
    logic [31:0]     rd;
    logic [31:0]     pick;
    logic [OP_W-1:0] op;
    logic            seen;
    int              acks;
    rst_i     = 1'b1;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    test_fail = 0;
    rng       = 32'd19;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;

    // Reset state
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      check_value("wb_ack_o idle", 32'(wb_ack_o), 32'd0);
    end
    for (int w = 0; w < 5; w++) begin
      wb_read(3'(w), rd);
      check_value($sformatf("wb_dat_o reg %0d after reset", w), rd,
                  (w == 4) ? 32'd1 : 32'd0);
    end
    end_test("reset_state");

    // Register access with byte lanes
    wb_write(REG_OPA, 32'h12345678, 4'hf);
    wb_write(REG_OPA, 32'haabbccdd, 4'b0101);
    wb_read(REG_OPA, rd);
    a = merge_bytes(32'h12345678, 32'haabbccdd, 4'b0101);
    check_value("wb_dat_o REG_OPA", rd, a);
    wb_write(REG_OPB, 32'h0f0f1234, 4'hf);
    wb_write(REG_OPB, 32'h55667788, 4'b1010);
    wb_read(REG_OPB, rd);
    b = merge_bytes(32'h0f0f1234, 32'h55667788, 4'b1010);
    check_value("wb_dat_o REG_OPB", rd, b);
    wb_write(REG_OP, 32'hffffffe5, 4'hf);
    wb_write(REG_OP, 32'h00000000, 4'b1110);
    wb_read(REG_OP, rd);
    check_value("wb_dat_o REG_OP", rd, 32'hffffffe5 & 32'h3f);
    wb_write(REG_OP, 32'(OP_ADD), 4'hf);
    wb_write(REG_RESULT, 32'hdeadbeef, 4'hf);
    for (int w = 5; w < 8; w++) begin
      wb_write(3'(w), 32'hffffffff, 4'hf);
      wb_read(3'(w), rd);
      check_value($sformatf("wb_dat_o unmapped %0d", w), rd, 32'd0);
    end
    wb_read(REG_RESULT, rd);
    check_value("wb_dat_o REG_RESULT", rd, model_result(OP_ADD, a, b));
    end_test("register_access");

    // Random operations over the whole code range
    for (int i = 0; i < 400; i++) begin
      next_rand(a);
      next_rand(b);
      next_rand(pick);
      op = OP_W'(pick % 32'd42);
      if (pick[15:12] == 4'd0) b = '0;
      if (pick[15:12] == 4'd1) b = a;
      run_op(op, a, b, res, br);
      check_value($sformatf("result op %0d", op), res, model_result(op, a, b));
      check_value($sformatf("branch op %0d", op), br, {31'b0, model_branch(op, a, b)});
    end
    end_test("random_ops");

    // Branch compares with equal and sign-flipped pairs
    for (int k = 0; k < 6; k++) begin
      op = OP_W'(OP_EQ + k);
      for (int j = 0; j < 16; j++) begin
        next_rand(a);
        next_rand(b);
        if (j % 4 == 0) b = a;
        if (j % 4 == 1) b = a ^ 32'h80000000;
        run_op(op, a, b, res, br);
        check_value($sformatf("branch op %0d", op), br, {31'b0, model_branch(op, a, b)});
        check_value($sformatf("result op %0d", op), res, model_result(op, a, b));
      end
    end
    run_op(OP_XOR, 32'h1, 32'h2, res, br);
    check_value("branch non-compare", br, 32'd1);
    end_test("branch");

    // Counting, shift extremes and undefined codes
    for (int v = 0; v < 6; v++) begin
      next_rand(pick);
      case (v)
        0:       a = 32'h00000000;
        1:       a = 32'hffffffff;
        2:       a = 32'h80000000;
        3:       a = 32'h00000001;
        4:       a = 32'h1 << pick[4:0];
        default: a = pick;
      endcase
      for (int k = 0; k < 3; k++) begin
        op = OP_W'(OP_CLZ + k);
        run_op(op, a, 32'd0, res, br);
        check_value($sformatf("result op %0d", op), res, model_result(op, a, 32'd0));
      end
    end
    next_rand(a);
    a = a | 32'h80000001;
    for (int s = 0; s < 2; s++) begin
      b = (s == 0) ? 32'd0 : 32'd31;
      run_op(OP_SLL, a, b, res, br);
      check_value("result SLL", res, model_result(OP_SLL, a, b));
      run_op(OP_SRL, a, b, res, br);
      check_value("result SRL", res, model_result(OP_SRL, a, b));
      run_op(OP_SRA, a, b, res, br);
      check_value("result SRA", res, model_result(OP_SRA, a, b));
      run_op(OP_ROL, a, b, res, br);
      check_value("result ROL", res, model_result(OP_ROL, a, b));
      run_op(OP_ROR, a, b, res, br);
      check_value("result ROR", res, model_result(OP_ROR, a, b));
    end
    for (int u = 42; u < 64; u += 7) begin
      run_op(OP_W'(u), 32'h12345678, 32'h9abcdef0, res, br);
      check_value($sformatf("result undefined op %0d", u), res, 32'd0);
      check_value($sformatf("branch undefined op %0d", u), br, 32'd1);
    end
    end_test("count_and_edges");

    // Two writes back to back with the strobe held high
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b1;
    wb_sel_i <= 4'hf;
    wb_adr_i <= {REG_OPA, 2'b00};
    wb_dat_i <= 32'hcafe0001;
    acks = 0;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk_i);
      seen = wb_ack_o;
      if (seen) acks++;
      @(posedge clk_i);
      if (seen && acks == 1) begin
        wb_adr_i <= {REG_OPB, 2'b00};
        wb_dat_i <= 32'hcafe0002;
      end else if (seen) begin
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
      end
    end
    check_value("wb_ack_o count", acks, 32'd2);
    wb_read(REG_OPA, rd);
    check_value("wb_dat_o REG_OPA", rd, 32'hcafe0001);
    wb_read(REG_OPB, rd);
    check_value("wb_dat_o REG_OPB", rd, 32'hcafe0002);
    end_test("ack_protocol");

    $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

`include "tb_alu_model.svh"

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verification
rtl/alu_pkg.sv
rtl/popcount.sv
rtl/lzc.sv
rtl/alu.sv
rtl/alu_wb_regs.sv
rtl/alu_wb_top.sv
verification/tb_alu_wb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_alu_wb_top -f files.f \
  --Mdir obj_dir -o sim_alu > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_alu > sim.log 2>&1 && cat sim.log || { cat sim.log; exit 1; }

grep -q "Simulation failed" sim.log && { echo "Result: FAIL"; exit 1; } || { echo "Result: PASS"; exit 0; }
